/* design/elastic_buffer.sv */
// two-entry valid/ready skid buffer
// registered output and registered ready_in
module elastic_buffer #(
    parameter int DATAW = 8
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             valid_in,
    output logic             ready_in,
    input  logic [DATAW-1:0] data_in,
    output logic             valid_out,
    input  logic             ready_out,
    output logic [DATAW-1:0] data_out
);
    logic             main_valid;
    logic             skid_valid;
    logic [DATAW-1:0] main_data;
    logic [DATAW-1:0] skid_data;
    logic             push;
    logic             pop;

    assign push = valid_in && ready_in;
    assign pop  = valid_out && ready_out;

    // skid entry full means both entries are taken
    assign ready_in  = !skid_valid;
    assign valid_out = main_valid;
    assign data_out  = main_data;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
        end else if (!main_valid || pop) begin
            // output slot free this edge so the skid entry drains first
            main_valid <= skid_valid || push;
            skid_valid <= 1'b0;
        end else if (push) begin
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!main_valid || pop) begin
            if (skid_valid) begin
                main_data <= skid_data;
            end else if (push) begin
                main_data <= data_in;
            end
        end else if (push) begin
            skid_data <= data_in;
        end
    end

    // a stalled output keeps its packet
    assert property (@(posedge clk) disable iff (!rst_n)
        valid_out && !ready_out |=> valid_out && $stable(data_out));

endmodule

/* design/sfu_wctl_top.sv */
// top level of the warp-control slice
// plain execute and commit ports, warp control unit and warp state
module sfu_wctl_top (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    output logic             in_ready,
    input  wctl_pkg::wid_t   in_wid,
    input  wctl_pkg::sfu_op_t in_op,
    input  wctl_pkg::lmask_t in_tmask,
    input  wctl_pkg::word_t  in_pc,
    input  wctl_pkg::word_t  in_rs1_0,
    input  wctl_pkg::word_t  in_rs1_1,
    input  wctl_pkg::word_t  in_rs2_0,
    input  wctl_pkg::word_t  in_rs2_1,
    input  logic             in_tid,
    input  wctl_pkg::pid_t   in_pid,
    input  logic             in_sop,
    input  logic             in_eop,
    output logic             commit_valid,
    input  logic             commit_ready,
    output wctl_pkg::wid_t   commit_wid,
    output wctl_pkg::lmask_t commit_tmask,
    output wctl_pkg::word_t  commit_pc,
    output wctl_pkg::pid_t   commit_pid,
    output logic             commit_sop,
    output logic             commit_eop,
    output logic             commit_halt,
    output wctl_pkg::word_t  commit_data,
    input  wctl_pkg::wid_t   status_wid,
    output wctl_pkg::tmask_t status_tmask,
    output wctl_pkg::word_t  status_pc,
    output wctl_pkg::depth_t status_depth,
    output wctl_pkg::wmask_t active_warps,
    output wctl_pkg::wmask_t stalled_warps
);
    exec_if     exec_bus ();
    warp_ctl_if wctl_bus ();

    assign exec_bus.valid  = in_valid;
    assign in_ready        = exec_bus.ready;
    assign exec_bus.wid    = in_wid;
    assign exec_bus.op     = in_op;
    assign exec_bus.tmask  = in_tmask;
    assign exec_bus.pc     = in_pc;
    assign exec_bus.rs1[0] = in_rs1_0;
    assign exec_bus.rs1[1] = in_rs1_1;
    assign exec_bus.rs2[0] = in_rs2_0;
    assign exec_bus.rs2[1] = in_rs2_1;
    assign exec_bus.tid    = in_tid;
    assign exec_bus.pid    = in_pid;
    assign exec_bus.sop    = in_sop;
    assign exec_bus.eop    = in_eop;

    warp_ctl_unit u_wctl (
        .clk          (clk),
        .rst_n        (rst_n),
        .exec         (exec_bus.slave),
        .warp_ctl     (wctl_bus.master),
        .commit_valid (commit_valid),
        .commit_ready (commit_ready),
        .commit_wid   (commit_wid),
        .commit_tmask (commit_tmask),
        .commit_pc    (commit_pc),
        .commit_pid   (commit_pid),
        .commit_sop   (commit_sop),
        .commit_eop   (commit_eop),
        .commit_halt  (commit_halt),
        .commit_data  (commit_data)
    );

    warp_state u_state (
        .clk           (clk),
        .rst_n         (rst_n),
        .warp_ctl      (wctl_bus.slave),
        .status_wid    (status_wid),
        .status_tmask  (status_tmask),
        .status_pc     (status_pc),
        .status_depth  (status_depth),
        .active_warps  (active_warps),
        .stalled_warps (stalled_warps)
    );

endmodule

/* design/warp_ctl_unit.sv */
// warp control unit
// op decode, then/else mask collection over packets, command build,
// commit path through a two-entry elastic buffer
`include "wctl_config.svh"

module warp_ctl_unit (
    input  logic            clk,
    input  logic            rst_n,
    exec_if.slave           exec,
    warp_ctl_if.master      warp_ctl,
    output logic            commit_valid,
    input  logic            commit_ready,
    output wctl_pkg::wid_t  commit_wid,
    output wctl_pkg::lmask_t commit_tmask,
    output wctl_pkg::word_t commit_pc,
    output wctl_pkg::pid_t  commit_pid,
    output logic            commit_sop,
    output logic            commit_eop,
    output logic            commit_halt,
    output wctl_pkg::word_t commit_data
);
    import wctl_pkg::*;

    localparam int CMDW = 7 + 3 * $bits(tmask_t) + 2 * $bits(word_t) + $bits(bar_id_t)
                        + $bits(wid_t) + $bits(wmask_t);
    localparam int DATAW = $bits(wid_t) + $bits(lmask_t) + $bits(word_t) + $bits(pid_t)
                         + 3 + CMDW;

    logic             is_tmc;
    logic             is_pred;
    logic             xfer;
    word_t            rs1_sel;
    word_t            rs2_sel;
    lmask_t           taken;
    tmask_t           then_r;
    tmask_t           else_r;
    tmask_t           then_n;
    tmask_t           else_n;
    tmask_t           tmc_mask;
    wmask_t           spawn_wmask;
    logic             halt;
    logic             halt_q;
    sfu_op_t          op_q;
    wid_t             wid_q;
    logic [DATAW-1:0] buf_in;
    logic [DATAW-1:0] buf_out;

    assign is_tmc  = (exec.op == `OP_TMC);
    assign is_pred = (exec.op == `OP_PRED);
    assign xfer    = exec.valid && exec.ready;

    // scalar operands come from the lane named by tid
    assign rs1_sel = exec.rs1[exec.tid];
    assign rs2_sel = exec.rs2[exec.tid];

    always_comb begin
        for (int i = 0; i < `NUM_LANES; i++) begin
            taken[i] = exec.rs1[i][0];
        end
        then_n = then_r;
        else_n = else_r;
        if (exec.sop) begin
            then_n = '0;
            else_n = '0;
        end
        then_n[exec.pid * `NUM_LANES +: `NUM_LANES] = taken & exec.tmask;
        else_n[exec.pid * `NUM_LANES +: `NUM_LANES] = ~taken & exec.tmask;
    end

    always_ff @(posedge clk) begin
        if (xfer) begin
            then_r <= then_n;
            else_r <= else_n;
        end
        if (xfer && exec.sop) begin
            op_q  <= exec.op;
            wid_q <= exec.wid;
        end
    end

    // pred falls back to rs2 when no thread is taken
    assign tmc_mask = (is_pred && then_n == '0) ? rs2_sel[`NUM_THREADS-1:0] :
                      is_pred ? then_n : rs1_sel[`NUM_THREADS-1:0];

    // tmc to an empty mask ends the warp
    assign halt = is_tmc && (tmc_mask == '0);

    always_comb begin
        for (int i = 0; i < `NUM_WARPS; i++) begin
            spawn_wmask[i] = (word_t'(i) < rs1_sel) && (wid_t'(i) != exec.wid);
        end
    end

    assign buf_in = {exec.wid, exec.tmask, exec.pc, exec.pid, exec.sop, exec.eop, halt,
                     is_tmc || is_pred, tmc_mask,
                     exec.op == `OP_SPLIT, (then_n != '0) && (else_n != '0),
                     then_n, else_n, exec.pc + word_t'(4),
                     exec.op == `OP_JOIN, rs1_sel[0],
                     exec.op == `OP_BAR, bar_id_t'(rs1_sel[0]), wid_t'(rs2_sel - word_t'(1)),
                     exec.op == `OP_WSPAWN, spawn_wmask, rs2_sel};

    elastic_buffer #(
        .DATAW (DATAW)
    ) rsp_buf (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid_in  (exec.valid),
        .ready_in  (exec.ready),
        .data_in   (buf_in),
        .valid_out (commit_valid),
        .ready_out (commit_ready),
        .data_out  (buf_out)
    );

    assign {commit_wid, commit_tmask, commit_pc, commit_pid, commit_sop, commit_eop, halt_q,
            warp_ctl.tmc_valid, warp_ctl.tmc_mask,
            warp_ctl.split_valid, warp_ctl.split_dvg,
            warp_ctl.then_mask, warp_ctl.else_mask, warp_ctl.next_pc,
            warp_ctl.join_valid, warp_ctl.join_dvg,
            warp_ctl.bar_valid, warp_ctl.bar_id, warp_ctl.bar_size_m1,
            warp_ctl.spawn_valid, warp_ctl.spawn_wmask, warp_ctl.spawn_pc} = buf_out;

    assign commit_halt = commit_valid && halt_q;
    assign commit_data = word_t'(warp_ctl.split_dvg);

    // command fires when the last packet leaves on commit
    assign warp_ctl.valid = commit_valid && commit_ready && commit_eop;
    assign warp_ctl.wid   = commit_wid;

    // all packets of one instruction share op and warp
    assert property (@(posedge clk) disable iff (!rst_n)
        xfer && !exec.sop |-> exec.op == op_q && exec.wid == wid_q);

endmodule

/* design/warp_state.sv */
// warp state
// per-warp thread masks, active and stalled sets, resume PCs,
// IPDOM reconvergence stacks and local barrier counters
`include "wctl_config.svh"

module warp_state (
    input  logic             clk,
    input  logic             rst_n,
    warp_ctl_if.slave        warp_ctl,
    input  wctl_pkg::wid_t   status_wid,
    output wctl_pkg::tmask_t status_tmask,
    output wctl_pkg::word_t  status_pc,
    output wctl_pkg::depth_t status_depth,
    output wctl_pkg::wmask_t active_warps,
    output wctl_pkg::wmask_t stalled_warps
);
    import wctl_pkg::*;

    localparam int SPW = $clog2(`IPDOM_DEPTH);

    tmask_t         warp_tmask [`NUM_WARPS];
    word_t          warp_pc    [`NUM_WARPS];
    depth_t         depth_r    [`NUM_WARPS];
    wmask_t         active_r;
    wmask_t         stalled_r;
    wid_t           bar_cnt    [`NUM_BARRIERS];
    wmask_t         bar_wait   [`NUM_BARRIERS];
    tmask_t         stk_mask   [`NUM_WARPS][`IPDOM_DEPTH];
    word_t          stk_pc     [`NUM_WARPS][`IPDOM_DEPTH];
    logic           stk_else   [`NUM_WARPS][`IPDOM_DEPTH];
    wid_t           w;
    bar_id_t        bid;
    logic [SPW-1:0] sp;
    logic [SPW-1:0] sp_next;
    logic [SPW-1:0] sp_top;
    logic           do_split;
    logic           do_join;

    assign w        = warp_ctl.wid;
    assign bid      = warp_ctl.bar_id;
    assign sp       = depth_r[w][SPW-1:0];
    assign sp_next  = sp + 1'b1;
    assign sp_top   = sp - 1'b1;
    assign do_split = warp_ctl.valid && warp_ctl.split_valid && warp_ctl.split_dvg;
    assign do_join  = warp_ctl.valid && warp_ctl.join_valid && warp_ctl.join_dvg;

    // stack entries with restore below else
    always_ff @(posedge clk) begin
        if (do_split) begin
            stk_mask[w][sp]      <= warp_tmask[w];
            stk_else[w][sp]      <= 1'b0;
            stk_mask[w][sp_next] <= warp_ctl.else_mask;
            stk_pc[w][sp_next]   <= warp_ctl.next_pc;
            stk_else[w][sp_next] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `NUM_WARPS; i++) begin
                warp_tmask[i] <= (i == 0) ? '1 : '0;
                warp_pc[i]    <= '0;
                depth_r[i]    <= '0;
            end
            active_r  <= wmask_t'(1);
            stalled_r <= '0;
            for (int b = 0; b < `NUM_BARRIERS; b++) begin
                bar_cnt[b]  <= '0;
                bar_wait[b] <= '0;
            end
        end else if (warp_ctl.valid) begin
            if (warp_ctl.tmc_valid) begin
                warp_tmask[w] <= warp_ctl.tmc_mask;
                if (warp_ctl.tmc_mask == '0) begin
                    active_r[w] <= 1'b0;
                end
            end
            if (do_split) begin
                warp_tmask[w] <= warp_ctl.then_mask;
                depth_r[w]    <= depth_r[w] + depth_t'(2);
            end
            if (do_join) begin
                warp_tmask[w] <= stk_mask[w][sp_top];
                // else path resumes at its own pc
                if (stk_else[w][sp_top]) begin
                    warp_pc[w] <= stk_pc[w][sp_top];
                end
                depth_r[w] <= depth_r[w] - depth_t'(1);
            end
            if (warp_ctl.bar_valid) begin
                if (bar_cnt[bid] == warp_ctl.bar_size_m1) begin
                    // last arrival releases every waiter
                    stalled_r    <= stalled_r & ~bar_wait[bid];
                    bar_wait[bid] <= '0;
                    bar_cnt[bid]  <= '0;
                end else begin
                    stalled_r[w]     <= 1'b1;
                    bar_wait[bid][w] <= 1'b1;
                    bar_cnt[bid]     <= bar_cnt[bid] + wid_t'(1);
                end
            end
            if (warp_ctl.spawn_valid) begin
                for (int i = 0; i < `NUM_WARPS; i++) begin
                    if (warp_ctl.spawn_wmask[i]) begin
                        active_r[i]   <= 1'b1;
                        warp_tmask[i] <= tmask_t'(1);
                        warp_pc[i]    <= warp_ctl.spawn_pc;
                    end
                end
            end
        end
    end

    assign status_tmask  = warp_tmask[status_wid];
    assign status_pc     = warp_pc[status_wid];
    assign status_depth  = depth_r[status_wid];
    assign active_warps  = active_r;
    assign stalled_warps = stalled_r;

    // a divergent split needs two free stack entries
    assert property (@(posedge clk) disable iff (!rst_n)
        do_split |-> depth_r[w] <= depth_t'(`IPDOM_DEPTH - 2));

    // a divergent join needs an entry to pop
    assert property (@(posedge clk) disable iff (!rst_n)
        do_join |-> depth_r[w] != '0);

endmodule

/* design/wctl_ifs.sv */
// exec_if carries execute packets into the warp control unit
// warp_ctl_if carries one command per instruction into the warp state
`include "wctl_config.svh"

interface exec_if;
    import wctl_pkg::*;

    logic    valid;
    logic    ready;
    wid_t    wid;
    sfu_op_t op;
    lmask_t  tmask;
    word_t   pc;
    word_t   rs1 [`NUM_LANES];
    word_t   rs2 [`NUM_LANES];
    // lane that carries the scalar operands
    logic    tid;
    pid_t    pid;
    logic    sop;
    logic    eop;

    modport master (output valid, wid, op, tmask, pc, rs1, rs2, tid, pid, sop, eop,
                    input ready);
    modport slave  (input valid, wid, op, tmask, pc, rs1, rs2, tid, pid, sop, eop,
                    output ready);
endinterface

interface warp_ctl_if;
    import wctl_pkg::*;

    // one-cycle strobe without back-pressure
    logic    valid;
    wid_t    wid;
    logic    tmc_valid;
    tmask_t  tmc_mask;
    logic    split_valid;
    logic    split_dvg;
    tmask_t  then_mask;
    tmask_t  else_mask;
    word_t   next_pc;
    logic    join_valid;
    logic    join_dvg;
    logic    bar_valid;
    bar_id_t bar_id;
    wid_t    bar_size_m1;
    logic    spawn_valid;
    wmask_t  spawn_wmask;
    word_t   spawn_pc;

    modport master (output valid, wid, tmc_valid, tmc_mask, split_valid, split_dvg,
                    then_mask, else_mask, next_pc, join_valid, join_dvg, bar_valid,
                    bar_id, bar_size_m1, spawn_valid, spawn_wmask, spawn_pc);
    modport slave  (input valid, wid, tmc_valid, tmc_mask, split_valid, split_dvg,
                    then_mask, else_mask, next_pc, join_valid, join_dvg, bar_valid,
                    bar_id, bar_size_m1, spawn_valid, spawn_wmask, spawn_pc);
endinterface

/* design/wctl_pkg.sv */
// shared vector types of the warp-control slice
// used by the RTL blocks and the testbench
`include "wctl_config.svh"

package wctl_pkg;

    // register value, also used for PCs
    typedef logic [`XLEN-1:0] word_t;

    // thread mask of a whole warp
    typedef logic [`NUM_THREADS-1:0] tmask_t;

    // lanes of a single packet
    typedef logic [`NUM_LANES-1:0] lmask_t;

    typedef logic [$clog2(`NUM_WARPS)-1:0] wid_t;
    typedef logic [`NUM_WARPS-1:0] wmask_t;

    // packet index inside one instruction
    typedef logic [$clog2(`NUM_THREADS / `NUM_LANES)-1:0] pid_t;

    typedef logic [2:0] sfu_op_t;
    typedef logic [$clog2(`NUM_BARRIERS)-1:0] bar_id_t;

    // ipdom stack occupancy from 0 up to IPDOM_DEPTH
    typedef logic [2:0] depth_t;

endpackage

/* sfu_wctl_top.f */
+incdir+.
design/wctl_pkg.sv
design/wctl_ifs.sv
design/elastic_buffer.sv
design/warp_ctl_unit.sv
design/warp_state.sv
design/sfu_wctl_top.sv
testbench/tb_sfu_wctl.sv

/* testbench/tb_sfu_wctl.sv */
// testbench for the warp-control slice
// clock, reset, Galois LFSR, typed compare tasks, commit monitor,
// directed tests for tmc, split/join, pred, wspawn, barrier and back-pressure
`include "wctl_config.svh"

module tb_sfu_wctl;
    import wctl_pkg::*;

    // 20 instructions over all tests plus reset and drain cycles
    localparam int NUM_INSTR   = 20;
    localparam int CYCLE_LIMIT = 40 * NUM_INSTR + 60;

    logic    clk, rst_n;
    logic    in_valid, in_ready, in_tid, in_sop, in_eop;
    wid_t    in_wid, commit_wid, status_wid;
    sfu_op_t in_op;
    lmask_t  in_tmask, commit_tmask;
    word_t   in_pc, in_rs1_0, in_rs1_1, in_rs2_0, in_rs2_1;
    pid_t    in_pid, commit_pid;
    logic    commit_valid, commit_ready, commit_sop, commit_eop, commit_halt;
    word_t   commit_pc, commit_data, status_pc;
    tmask_t  status_tmask;
    depth_t  status_depth;
    wmask_t  active_warps, stalled_warps;

    int          mismatches, failures, cycles;
    // packets accepted, packets committed, cycles seen with in_ready low
    int          acc_count, com_count, full_seen;
    logic        stall_mode;
    logic [15:0] rnd_state, stall_state;
    logic        halt_log [256];
    word_t       data_log [256];
    wid_t        exp_wid [$];
    lmask_t      exp_tmask [$];
    word_t       exp_pc [$];
    pid_t        exp_pid [$];

    sfu_wctl_top dut0 (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            failures++;
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    // one LFSR step per bit taken
    function automatic word_t rand_bits(input int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            rnd_state = lfsr_next(rnd_state);
            v = {v[`XLEN-2:0], rnd_state[0]};
        end
        return v;
    endfunction

    task automatic log_mismatch(input string name, input word_t got, input word_t exp);
        mismatches++;
        $display("Mismatch at time %0t: %s is %h, expected %h", $time, name, got, exp);
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) log_mismatch(name, got, exp);
    endtask

    task automatic check_tmask(input string name, input tmask_t got, input tmask_t exp);
        if (got !== exp) log_mismatch(name, word_t'(got), word_t'(exp));
    endtask

    task automatic check_lmask(input string name, input lmask_t got, input lmask_t exp);
        if (got !== exp) log_mismatch(name, word_t'(got), word_t'(exp));
    endtask

    task automatic check_wmask(input string name, input wmask_t got, input wmask_t exp);
        if (got !== exp) log_mismatch(name, word_t'(got), word_t'(exp));
    endtask

    task automatic check_depth(input string name, input depth_t got, input depth_t exp);
        if (got !== exp) log_mismatch(name, word_t'(got), word_t'(exp));
    endtask

    task automatic check_wid(input string name, input wid_t got, input wid_t exp);
        if (got !== exp) log_mismatch(name, word_t'(got), word_t'(exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) log_mismatch(name, word_t'(got), word_t'(exp));
    endtask

    // commit side drives commit_ready and checks packets in issue order
    always @(negedge clk) begin
        if (rst_n) begin
            // in_ready low exactly while both buffer entries hold a packet
            check_bit("in_ready", in_ready, (acc_count - com_count) != 2);
            if (!in_ready) begin
                full_seen++;
            end
            if (stall_mode) begin
                stall_state  = lfsr_next(stall_state);
                commit_ready = stall_state[0];
            end else begin
                commit_ready = 1'b1;
            end
            if (commit_valid && commit_ready) begin
                if (exp_pc.size() == 0) begin
                    failures++;
                    $display("commit at time %0t with no packet outstanding", $time);
                end else begin
                    check_wid("commit_wid", commit_wid, exp_wid.pop_front());
                    check_lmask("commit_tmask", commit_tmask, exp_tmask.pop_front());
                    check_word("commit_pc", commit_pc, exp_pc.pop_front());
                    check_bit("commit_sop", commit_sop, exp_pid[0] == 0);
                    check_bit("commit_eop", commit_eop, exp_pid[0] == 1);
                    check_bit("commit_pid", commit_pid, exp_pid.pop_front());
                end
                halt_log[com_count] = commit_halt;
                data_log[com_count] = commit_data;
                com_count++;
            end
        end
    end

    // one packet held until accepted
    // lane 0 carries the scalar operands
    task automatic send_packet(input wid_t wid, input sfu_op_t op, input word_t pc,
                               input pid_t pid, input word_t rs1_a, input word_t rs1_b,
                               input word_t rs2);
        @(negedge clk);
        in_valid = 1'b1;
        in_wid   = wid;
        in_op    = op;
        in_pc    = pc;
        in_pid   = pid;
        in_sop   = (pid == 0);
        in_eop   = (pid == 1);
        in_rs1_0 = rs1_a;
        in_rs1_1 = rs1_b;
        in_rs2_0 = rs2;
        in_rs2_1 = rs2;
        exp_wid.push_back(wid);
        exp_tmask.push_back(in_tmask);
        exp_pc.push_back(pc);
        exp_pid.push_back(pid);
        while (!in_ready) @(negedge clk);
        @(posedge clk);
        acc_count++;
    endtask

    // r0..r3 are the rs1 values of threads 0..3
    task automatic issue(input wid_t wid, input sfu_op_t op, input word_t pc,
                         input word_t r0, input word_t r1, input word_t r2,
                         input word_t r3, input word_t rs2);
        send_packet(wid, op, pc, 1'b0, r0, r1, rs2);
        send_packet(wid, op, pc, 1'b1, r2, r3, rs2);
    endtask

    // wait for all commits and then for the command edge
    task automatic drain;
        @(negedge clk);
        in_valid = 1'b0;
        wait (com_count == acc_count);
        @(posedge clk);
        @(negedge clk);
    endtask

    task automatic check_warp(input wid_t w, input tmask_t tmask, input word_t pc,
                              input depth_t depth);
        status_wid = w;
        #1;
        check_tmask("status_tmask", status_tmask, tmask);
        check_word("status_pc", status_pc, pc);
        check_depth("status_depth", status_depth, depth);
    endtask

    task automatic test_tmc;
        issue(2'd0, `OP_TMC, 32'h40, 32'h5, 32'h5, 32'h5, 32'h5, '0);
        drain();
        check_warp(2'd0, 4'b0101, '0, '0);
        check_bit("commit_halt", halt_log[com_count - 1], 1'b0);
        // empty mask ends the warp
        issue(2'd0, `OP_TMC, 32'h44, '0, '0, '0, '0, '0);
        drain();
        check_bit("commit_halt", halt_log[com_count - 2], 1'b1);
        check_bit("commit_halt", halt_log[com_count - 1], 1'b1);
        check_bit("active_warps[0]", active_warps[0], 1'b0);
    endtask

    task automatic test_split_join;
        tmask_t then_m;
        tmask_t else_m;
        issue(2'd0, `OP_TMC, 32'h80, 32'hf, 32'hf, 32'hf, 32'hf, '0);
        drain();
        // lanes 1,0 then 0,1 taken give threads 0 and 3
        then_m = 4'b1001;
        else_m = ~then_m;
        issue(2'd0, `OP_SPLIT, 32'h100, 32'h1, 32'h0, 32'h0, 32'h1, '0);
        drain();
        check_word("commit_data", data_log[com_count - 1], 32'd1);
        check_warp(2'd0, then_m, '0, 3'd2);
        issue(2'd0, `OP_JOIN, 32'h120, 32'h1, 32'h1, 32'h1, 32'h1, '0);
        drain();
        check_warp(2'd0, else_m, 32'h104, 3'd1);
        issue(2'd0, `OP_JOIN, 32'h124, 32'h1, 32'h1, 32'h1, 32'h1, '0);
        drain();
        check_warp(2'd0, 4'hf, 32'h104, 3'd0);
        // uniform branch pushes nothing
        issue(2'd0, `OP_SPLIT, 32'h128, 32'h1, 32'h1, 32'h1, 32'h1, '0);
        drain();
        check_word("commit_data", data_log[com_count - 1], 32'd0);
        check_warp(2'd0, 4'hf, 32'h104, 3'd0);
    endtask

    task automatic test_pred;
        tmask_t taken;
        word_t  rs2;
        taken = tmask_t'(rand_bits(4)) | 4'b0010;
        rs2   = rand_bits(32);
        issue(2'd0, `OP_PRED, 32'h200, taken[0], taken[1], taken[2], taken[3], rs2);
        drain();
        check_warp(2'd0, taken, 32'h104, '0);
        // no thread taken so the mask comes from rs2
        rs2 = rand_bits(32);
        issue(2'd0, `OP_PRED, 32'h204, '0, '0, '0, '0, rs2);
        drain();
        check_warp(2'd0, rs2[3:0], 32'h104, '0);
    endtask

    task automatic test_spawn;
        word_t  spawn_pc;
        wmask_t exp_active;
        spawn_pc   = rand_bits(32);
        // warp 0 stays halted from the tmc test
        exp_active = '0;
        // warps below the count of 3 except the issuing warp 0
        for (int i = 0; i < `NUM_WARPS; i++) begin
            if (i < 3 && i != 0) begin
                exp_active[i] = 1'b1;
            end
        end
        issue(2'd0, `OP_WSPAWN, 32'h300, 32'd3, 32'd3, 32'd3, 32'd3, spawn_pc);
        drain();
        check_wmask("active_warps", active_warps, exp_active);
        check_warp(2'd1, 4'b0001, spawn_pc, '0);
        check_warp(2'd2, 4'b0001, spawn_pc, '0);
    endtask

    task automatic test_barrier;
        issue(2'd1, `OP_BAR, 32'h400, '0, '0, '0, '0, 32'd2);
        drain();
        check_wmask("stalled_warps", stalled_warps, 4'b0010);
        issue(2'd2, `OP_BAR, 32'h404, '0, '0, '0, '0, 32'd2);
        drain();
        check_wmask("stalled_warps", stalled_warps, 4'b0000);
    endtask

    task automatic test_backpressure;
        word_t r;
        stall_mode = 1'b1;
        full_seen  = 0;
        // non-divergent joins leave the warp state alone
        for (int n = 0; n < 8; n++) begin
            r = rand_bits(32) & ~32'h1;
            issue(wid_t'(n), `OP_JOIN, 32'h500 + 4 * n, r, r, r, r, rand_bits(32));
        end
        drain();
        stall_mode = 1'b0;
        if (full_seen == 0) begin
            failures++;
            $display("in_ready never fell while commit_ready was stalled");
        end
    endtask

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        in_wid       = '0;
        in_op        = '0;
        in_tmask     = '1;
        in_pc        = '0;
        in_rs1_0     = '0;
        in_rs1_1     = '0;
        in_rs2_0     = '0;
        in_rs2_1     = '0;
        in_tid       = 1'b0;
        in_pid       = '0;
        in_sop       = 1'b0;
        in_eop       = 1'b0;
        commit_ready = 1'b1;
        status_wid   = '0;
        stall_mode   = 1'b0;
        rnd_state    = 16'd20;
        stall_state  = 16'd20;
        mismatches   = 0;
        failures     = 0;
        cycles       = 0;
        acc_count    = 0;
        com_count    = 0;
        full_seen    = 0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        check_warp(2'd0, '1, '0, '0);
        check_wmask("active_warps", active_warps, 4'b0001);
        check_wmask("stalled_warps", stalled_warps, 4'b0000);
        test_tmc();
        test_split_join();
        test_pred();
        test_spawn();
        test_barrier();
        test_backpressure();
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches + failures == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* wctl_config.svh */
// sizes and op codes for the warp-control slice
// warp, thread and lane counts, XLEN, barriers, IPDOM depth
`ifndef WCTL_CONFIG_SVH
`define WCTL_CONFIG_SVH

// core geometry
`define NUM_WARPS    4
`define NUM_THREADS  4
`define NUM_LANES    2
`define XLEN         32

// synchronization resources
`define NUM_BARRIERS 2
`define IPDOM_DEPTH  4

// thread-control op codes from execute
`define OP_TMC    3'd0
`define OP_PRED   3'd1
`define OP_SPLIT  3'd2
`define OP_JOIN   3'd3
`define OP_BAR    3'd4
`define OP_WSPAWN 3'd5

`endif
